//--- isa_pkg.sv
package isa_pkg;

    localparam int word_width      = 32; // Data and address width
    localparam int reg_index_width = 5;  // 32 registers
    localparam int opcode_width    = 6;
    localparam int funct_width     = 6;
    localparam int imm_width       = 16; // I-type immediate field
    localparam int index_width     = 26; // J-type target field

    // Primary opcodes
    localparam logic [opcode_width-1:0] op_rtype = 6'b000000; // Decoded further by funct
    localparam logic [opcode_width-1:0] op_j     = 6'b000010;
    localparam logic [opcode_width-1:0] op_jal   = 6'b000011;
    localparam logic [opcode_width-1:0] op_beq   = 6'b000100;
    localparam logic [opcode_width-1:0] op_bne   = 6'b000101;
    localparam logic [opcode_width-1:0] op_addi  = 6'b001000;
    localparam logic [opcode_width-1:0] op_addiu = 6'b001001;
    localparam logic [opcode_width-1:0] op_slti  = 6'b001010;
    localparam logic [opcode_width-1:0] op_sltiu = 6'b001011;
    localparam logic [opcode_width-1:0] op_andi  = 6'b001100;
    localparam logic [opcode_width-1:0] op_ori   = 6'b001101;
    localparam logic [opcode_width-1:0] op_xori  = 6'b001110;
    localparam logic [opcode_width-1:0] op_lui   = 6'b001111;
    localparam logic [opcode_width-1:0] op_lb    = 6'b100000;
    localparam logic [opcode_width-1:0] op_lh    = 6'b100001;
    localparam logic [opcode_width-1:0] op_lw    = 6'b100011;
    localparam logic [opcode_width-1:0] op_lbu   = 6'b100100;
    localparam logic [opcode_width-1:0] op_lhu   = 6'b100101;
    localparam logic [opcode_width-1:0] op_lwu   = 6'b100111;
    localparam logic [opcode_width-1:0] op_sb    = 6'b101000;
    localparam logic [opcode_width-1:0] op_sh    = 6'b101001;
    localparam logic [opcode_width-1:0] op_sw    = 6'b101011;

    // R-type funct codes
    localparam logic [funct_width-1:0] fn_sll  = 6'b000000;
    localparam logic [funct_width-1:0] fn_srl  = 6'b000010;
    localparam logic [funct_width-1:0] fn_sra  = 6'b000011;
    localparam logic [funct_width-1:0] fn_sllv = 6'b000100;
    localparam logic [funct_width-1:0] fn_srlv = 6'b000110;
    localparam logic [funct_width-1:0] fn_srav = 6'b000111;
    localparam logic [funct_width-1:0] fn_jr   = 6'b001000;
    localparam logic [funct_width-1:0] fn_jalr = 6'b001001;
    localparam logic [funct_width-1:0] fn_addu = 6'b100001;
    localparam logic [funct_width-1:0] fn_subu = 6'b100011;
    localparam logic [funct_width-1:0] fn_and  = 6'b100100;
    localparam logic [funct_width-1:0] fn_or   = 6'b100101;
    localparam logic [funct_width-1:0] fn_xor  = 6'b100110;
    localparam logic [funct_width-1:0] fn_nor  = 6'b100111;
    localparam logic [funct_width-1:0] fn_slt  = 6'b101010;
    localparam logic [funct_width-1:0] fn_sltu = 6'b101011;

    typedef struct packed {
        logic [opcode_width-1:0]    opcode;
        logic [reg_index_width-1:0] rs;
        logic [reg_index_width-1:0] rt;
        logic [reg_index_width-1:0] rd;
        logic [reg_index_width-1:0] shamt;
        logic [funct_width-1:0]     funct;
    } r_view_t;

    typedef struct packed {
        logic [opcode_width-1:0]    opcode;
        logic [reg_index_width-1:0] rs;
        logic [reg_index_width-1:0] rt;
        logic [imm_width-1:0]       imm16;
    } i_view_t;

    typedef struct packed {
        logic [opcode_width-1:0] opcode;
        logic [index_width-1:0]  index26;
    } j_view_t;

    // Same 32-bit word, three field layouts
    typedef union packed {
        r_view_t r;
        i_view_t i;
        j_view_t j;
    } instr_u;

endpackage

//--- ctrl_pkg.sv
package ctrl_pkg;

    localparam int control_width = 18;
    localparam int alu_op_width  = 3;

    // Control word bit positions
    localparam int reg_write   = 0;  // Write result to register file
    localparam int branch      = 1;  // Conditional branch
    localparam int unsigned_op = 2;  // Unsigned arithmetic or load
    localparam int mem_read    = 3;
    localparam int mem_write   = 4;
    localparam int mask_1      = 5;  // Sub-word access, with mask_2
    localparam int mask_2      = 6;  // Byte access when both masks set
    localparam int reg_dst     = 7;  // Destination from rd, else rt
    localparam int shift_src   = 8;  // Shift amount from shamt field
    localparam int alu_src     = 9;  // Second ALU operand is the immediate
    localparam int alu_op_lo   = 10; // Low bit of the 3-bit ALU op field
    localparam int mem_to_reg  = 13; // Write-back from memory
    localparam int j_ret_dst   = 14; // Register-target jump
    localparam int eq_or_ne    = 15; // Invert branch compare (BNE)
    localparam int jump_src    = 16; // Jump target from rs
    localparam int jump_or_b   = 17; // Any control transfer

    // ALU operation codes in bits 12..10
    localparam logic [alu_op_width-1:0] alu_sub = 3'd0;
    localparam logic [alu_op_width-1:0] alu_add = 3'd1;
    localparam logic [alu_op_width-1:0] alu_slt = 3'd2;
    localparam logic [alu_op_width-1:0] alu_and = 3'd3;
    localparam logic [alu_op_width-1:0] alu_or  = 3'd4;
    localparam logic [alu_op_width-1:0] alu_xor = 3'd5;
    localparam logic [alu_op_width-1:0] alu_lui = 3'd6;

endpackage

//--- reg_read_if.sv
interface reg_read_if;
    import isa_pkg::*;

    logic [reg_index_width-1:0] rs_addr; // First source index
    logic [reg_index_width-1:0] rt_addr; // Second source index
    logic [word_width-1:0]      rs_data;
    logic [word_width-1:0]      rt_data;

    // Decode side drives addresses, reads data back in the same cycle
    modport requester (
        output rs_addr, rt_addr,
        input  rs_data, rt_data
    );

    modport file (
        input  rs_addr, rt_addr,
        output rs_data, rt_data
    );

endinterface

//--- main_control.sv
module main_control (
    input  logic                                clk,    // Assertion sampling only
    input  isa_pkg::instr_u                     instr,
    output logic [ctrl_pkg::control_width-1:0] control
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic [opcode_width+funct_width-1:0] op_fn; // Opcode joined with funct

    assign op_fn = {instr.r.opcode, instr.r.funct};

    // Groups left to right are bits 17..13, alu_op, bits 9..7 and bits 6..0
    always_comb begin
        casez (op_fn)
            // R-type ALU op 111 leaves the operation to funct
            {op_rtype, fn_sll}:  control = 18'b00000_111_011_0000001; // Shift by shamt
            {op_rtype, fn_srl}:  control = 18'b00000_111_011_0000001;
            {op_rtype, fn_sra}:  control = 18'b00000_111_011_0000001;
            {op_rtype, fn_sllv}: control = 18'b00000_111_001_0000001; // Shift by rs
            {op_rtype, fn_srlv}: control = 18'b00000_111_001_0000001;
            {op_rtype, fn_srav}: control = 18'b00000_111_001_0000001;
            {op_rtype, fn_addu}: control = 18'b00000_111_001_0000101;
            {op_rtype, fn_subu}: control = 18'b00000_111_001_0000101;
            {op_rtype, fn_and}:  control = 18'b00000_111_001_0000101;
            {op_rtype, fn_or}:   control = 18'b00000_111_001_0000101;
            {op_rtype, fn_xor}:  control = 18'b00000_111_001_0000101;
            {op_rtype, fn_nor}:  control = 18'b00000_111_001_0000101;
            {op_rtype, fn_slt}:  control = 18'b00000_111_001_0000001; // Signed compare
            {op_rtype, fn_sltu}: control = 18'b00000_111_001_0000101;
            {op_rtype, fn_jr}:   control = 18'b11010_000_000_0000000; // Target from rs
            {op_rtype, fn_jalr}: control = 18'b11010_000_000_0000001; // Same, plus link

            // Loads add base and offset, mem_to_reg set
            {op_lb,  6'b??????}: control = 18'b00001_001_100_1101001;
            {op_lh,  6'b??????}: control = 18'b00001_001_100_0101001;
            {op_lw,  6'b??????}: control = 18'b00001_001_100_0001001;
            {op_lwu, 6'b??????}: control = 18'b00001_001_100_0001101;
            {op_lbu, 6'b??????}: control = 18'b00001_001_100_1101101;
            {op_lhu, 6'b??????}: control = 18'b00001_001_100_0101101;

            // Stores never write the register file
            {op_sb, 6'b??????}:  control = 18'b00000_001_100_1110000;
            {op_sh, 6'b??????}:  control = 18'b00000_001_100_0110000;
            {op_sw, 6'b??????}:  control = 18'b00000_001_100_0010000;

            // Immediate ALU
            {op_addi,  6'b??????}: control = 18'b00000_001_100_0000001;
            {op_addiu, 6'b??????}: control = 18'b00000_001_100_0000101;
            {op_andi,  6'b??????}: control = 18'b00000_011_100_0000101; // Zero-extended imm
            {op_ori,   6'b??????}: control = 18'b00000_100_100_0000101;
            {op_xori,  6'b??????}: control = 18'b00000_101_100_0000101;
            {op_lui,   6'b??????}: control = 18'b00000_110_100_0000101; // Imm in upper half
            {op_slti,  6'b??????}: control = 18'b00000_010_100_0000001;
            {op_sltiu, 6'b??????}: control = 18'b00000_010_100_0000101;

            // Branches differ only in eq_or_ne
            {op_beq, 6'b??????}: control = 18'b10000_000_000_0000010;
            {op_bne, 6'b??????}: control = 18'b10100_000_000_0000010;

            // Pseudo-direct jumps, jump_src clear
            {op_j,   6'b??????}: control = 18'b10000_000_000_0000000;
            {op_jal, 6'b??????}: control = 18'b10000_000_000_0000001; // Link to $31 later

            default: control = '0; // Unknown encoding acts as a bubble
        endcase
    end

    // Memory access is either a load or a store, never both
    a_mem_exclusive: assert property (
        @(posedge clk) !(control[mem_read] && control[mem_write])
    ) else $error("mem_read and mem_write both set, instr %h", instr);

    // Register jumps are a subset of control transfers
    a_jump_src_in_jump: assert property (
        @(posedge clk) control[jump_src] |-> control[jump_or_b]
    ) else $error("jump_src without jump_or_b, instr %h", instr);

endmodule

//--- register_file.sv
module register_file #(
    parameter int write_bypass = 1 // 1 forwards wb_data to a same-cycle read
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                wb_enable,
    input  logic [isa_pkg::reg_index_width-1:0] wb_addr,
    input  logic [isa_pkg::word_width-1:0]      wb_data,
    reg_read_if.file                            rd
);
    import isa_pkg::*;

    localparam int reg_count = 1 << reg_index_width;

    logic [word_width-1:0] regs [reg_count]; // Storage, entry 0 unused on read

    // One function serves both read ports
    function automatic logic [word_width-1:0] read_port(
        input logic [reg_index_width-1:0] addr
    );
        logic bypass_hit;
        bypass_hit = (write_bypass != 0) && wb_enable && (wb_addr == addr);
        if (addr == '0) begin
            return '0;          // $zero is hard-wired
        end else if (bypass_hit) begin
            return wb_data;     // Write in flight wins
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_enable && (wb_addr != '0)) begin // Writes to $0 dropped
            regs[wb_addr] <= wb_data;
        end
    end

    always_comb begin
        rd.rs_data = read_port(rd.rs_addr);
        rd.rt_data = read_port(rd.rt_addr);
    end

    // An unknown write index would corrupt an arbitrary register
    a_wb_addr_known: assert property (
        @(posedge clk) disable iff (reset)
        wb_enable |-> !$isunknown(wb_addr)
    ) else $error("wb_addr unknown while wb_enable high");

endmodule

//--- operand_fetch.sv
module operand_fetch (
    input  logic                                clk,      // Assertion sampling only
    input  isa_pkg::instr_u                     instr,
    input  logic [isa_pkg::word_width-1:0]      pc,
    input  logic [ctrl_pkg::control_width-1:0] control,
    reg_read_if.requester                       rd,
    output logic [isa_pkg::word_width-1:0]      rs_value,
    output logic [isa_pkg::word_width-1:0]      rt_value,
    output logic [isa_pkg::word_width-1:0]      imm_value,
    output logic [isa_pkg::reg_index_width-1:0] shamt,
    output logic                                redirect,
    output logic [isa_pkg::word_width-1:0]      target
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic [alu_op_width-1:0] alu_op;
    logic [word_width-1:0]   sign_ext;      // Sign-extended imm16
    logic [word_width-1:0]   pc_plus4;
    logic [word_width-1:0]   branch_target;
    logic [word_width-1:0]   jump_target;   // Pseudo-direct J/JAL target
    logic                    operands_equal;

    // Register operands, read combinationally
    assign rd.rs_addr = instr.r.rs;
    assign rd.rt_addr = instr.r.rt;
    assign rs_value   = rd.rs_data;
    assign rt_value   = rd.rt_data;
    assign shamt      = instr.r.shamt;

    assign alu_op   = control[alu_op_lo +: alu_op_width];
    assign sign_ext = {{(word_width-imm_width){instr.i.imm16[imm_width-1]}}, instr.i.imm16};

    // Logical ops take the raw immediate, LUI places it high
    always_comb begin
        case (alu_op)
            alu_and, alu_or, alu_xor: imm_value = {{(word_width-imm_width){1'b0}}, instr.i.imm16};
            alu_lui:                  imm_value = {instr.i.imm16, {(word_width-imm_width){1'b0}}};
            default:                  imm_value = sign_ext;
        endcase
    end

    assign pc_plus4       = pc + word_width'(4);
    assign branch_target  = pc_plus4 + {sign_ext[word_width-3:0], 2'b00}; // Word offset
    assign jump_target    = {pc_plus4[word_width-1 -: 4], instr.j.index26, 2'b00};
    assign operands_equal = (rd.rs_data == rd.rt_data);

    always_comb begin
        if (control[branch]) begin
            redirect = operands_equal ^ control[eq_or_ne]; // BNE inverts the compare
        end else begin
            redirect = control[jump_or_b];                 // Unconditional jumps
        end
    end

    always_comb begin
        if (!redirect) begin
            target = pc_plus4;         // Fall through
        end else if (control[branch]) begin
            target = branch_target;
        end else if (control[jump_src]) begin
            target = rd.rs_data;       // JR/JALR
        end else begin
            target = jump_target;
        end
    end

    // Target mux ranks a branch above a register jump, never both decoded
    a_branch_not_jump_src: assert property (
        @(posedge clk) !(control[branch] && control[jump_src])
    ) else $error("branch and jump_src both set, instr %h", instr);

endmodule

//--- decode_stage.sv
module decode_stage #(
    parameter int write_bypass = 1 // Same-cycle write-to-read forwarding
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [isa_pkg::word_width-1:0]      instr,
    input  logic [isa_pkg::word_width-1:0]      pc,
    input  logic                                wb_enable,  // From write-back stage
    input  logic [isa_pkg::reg_index_width-1:0] wb_addr,
    input  logic [isa_pkg::word_width-1:0]      wb_data,
    output logic [ctrl_pkg::control_width-1:0] control,
    output logic [isa_pkg::word_width-1:0]      rs_value,
    output logic [isa_pkg::word_width-1:0]      rt_value,
    output logic [isa_pkg::word_width-1:0]      imm_value,
    output logic [isa_pkg::reg_index_width-1:0] shamt,
    output logic                                redirect,   // Taken branch or jump
    output logic [isa_pkg::word_width-1:0]      target      // Next fetch address
);

    reg_read_if rd_bus (); // Operand fetch to register file

    main_control u_main_control (
        .clk     (clk),
        .instr   (instr),   // Raw word, viewed through the union
        .control (control)
    );

    register_file #(
        .write_bypass (write_bypass)
    ) u_register_file (
        .clk       (clk),
        .reset     (reset),
        .wb_enable (wb_enable),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .rd        (rd_bus)
    );

    operand_fetch u_operand_fetch (
        .clk       (clk),
        .instr     (instr),
        .pc        (pc),
        .control   (control),
        .rd        (rd_bus),
        .rs_value  (rs_value),
        .rt_value  (rt_value),
        .imm_value (imm_value),
        .shamt     (shamt),
        .redirect  (redirect),
        .target    (target)
    );

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen #(
    parameter int period = 100 // Full clock period
) (
    output logic clk
);
    initial clk = 1'b0;
    always #(period / 2) clk = ~clk; // Equal high and low phases
endmodule

//--- decode_stage_tb.sv
module decode_stage_tb;
    import isa_pkg::*;
    import ctrl_pkg::*;

    localparam int period       = 100;
    localparam int reset_cycles = 10;

    logic                       clk;
    logic                       reset;
    logic                       wb_enable;
    logic                       redirect;
    logic [word_width-1:0]      instr, pc, wb_data;
    logic [word_width-1:0]      rs_value, rt_value, imm_value, target;
    logic [reg_index_width-1:0] wb_addr, shamt;
    logic [control_width-1:0]   control;
    logic [word_width-1:0]      shadow [32];    // Register model
    logic [word_width-1:0]      rng = 32'h112b; // xorshift state
    logic [81:0]                rows [$];       // {instr, pc, expected control}
    int                         cycles = 0;
    int                         cycle_limit = 0;

    tb_clock_gen #(.period(period)) u_clock_gen (.clk(clk));
    decode_stage #(.write_bypass(1)) DUT (.*);

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] r_word(input logic [4:0] rs, rt, rd, sh,
                                           input logic [5:0] fn);
        return {op_rtype, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs, rt,
                                           input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic check_control(input string name, input logic [control_width-1:0] got, exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_word(input string name, input logic [word_width-1:0] got, exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    // Expected outputs from the decode rules and the shadow registers
    task automatic compare_outputs(input logic [control_width-1:0] ctrl);
        instr_u                  w;
        logic [word_width-1:0]   sext, imm_exp, pc4, tgt_exp;
        logic [alu_op_width-1:0] op;
        logic                    taken;
        w    = instr;
        op   = ctrl[alu_op_lo +: alu_op_width];
        sext = {{16{w.i.imm16[15]}}, w.i.imm16};
        pc4  = pc + 32'd4;
        if (op == alu_and || op == alu_or || op == alu_xor) imm_exp = {16'h0, w.i.imm16};
        else if (op == alu_lui) imm_exp = {w.i.imm16, 16'h0};
        else imm_exp = sext;
        taken = ctrl[branch] ? ((shadow[w.r.rs] == shadow[w.r.rt]) ^ ctrl[eq_or_ne])
                             : ctrl[jump_or_b];
        if (!taken) tgt_exp = pc4;                              // Fall through
        else if (ctrl[branch]) tgt_exp = pc4 + (sext << 2);     // Word offset
        else if (ctrl[jump_src]) tgt_exp = shadow[w.r.rs];      // JR, JALR
        else tgt_exp = {pc4[31:28], w.j.index26, 2'b00};        // Pseudo-direct
        check_control("control", control, ctrl);
        check_word("rs_value", rs_value, shadow[w.r.rs]);
        check_word("rt_value", rt_value, shadow[w.r.rt]);
        check_word("imm_value", imm_value, imm_exp);
        check_word("shamt", 32'(shamt), 32'(w.r.shamt));
        check_bit("redirect", redirect, taken);
        check_word("target", target, tgt_exp);
    endtask

    // Drive on the falling edge, compare halfway through the low phase
    task automatic drive_and_check(input logic [word_width-1:0] word, addr,
                                   input logic [control_width-1:0] ctrl, input logic we,
                                   input logic [reg_index_width-1:0] wa,
                                   input logic [word_width-1:0] wd);
        @(negedge clk);
        instr     = word;
        pc        = addr;
        wb_enable = we;
        wb_addr   = wa;
        wb_data   = wd;
        if (we && wa != '0) shadow[wa] = wd; // Bypass shows the write at once
        #(period / 4);
        compare_outputs(ctrl);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("*** FAILED ***");
            $fatal(1, "Timeout, the test sequence did not finish in %0d cycles", cycles);
        end
    end

    initial begin
        instr     = '0; // SLL $0 while in reset
        pc        = '0;
        wb_enable = 1'b0;
        wb_addr   = '0;
        wb_data   = '0;
        reset     = 1'b1;
        foreach (shadow[i]) shadow[i] = '0;
        rows.push_back({r_word(5'd0, 5'd3, 5'd4, 5'd7, fn_sll), 32'h0000_0040, 18'h01D81});
        rows.push_back({r_word(5'd0, 5'd5, 5'd6, 5'd31, fn_sra), 32'h0000_0044, 18'h01D81});
        rows.push_back({r_word(5'd2, 5'd3, 5'd4, 5'd0, fn_srlv), 32'h0000_0048, 18'h01C81});
        rows.push_back({r_word(5'd1, 5'd2, 5'd3, 5'd0, fn_addu), 32'h0000_004c, 18'h01C85});
        rows.push_back({r_word(5'd6, 5'd7, 5'd8, 5'd0, fn_slt), 32'h0000_0050, 18'h01C81});
        rows.push_back({r_word(5'd12, 5'd0, 5'd0, 5'd0, fn_jr), 32'h0000_0054, 18'h34000});
        rows.push_back({r_word(5'd13, 5'd0, 5'd31, 5'd0, fn_jalr), 32'h0000_0058, 18'h34001});
        rows.push_back({i_word(op_lb, 5'd4, 5'd5, 16'hfffc), 32'h0000_0060, 18'h02669});
        rows.push_back({i_word(op_lhu, 5'd4, 5'd5, 16'h0010), 32'h0000_0064, 18'h0262D});
        rows.push_back({i_word(op_sw, 5'd6, 5'd7, 16'h0008), 32'h0000_0068, 18'h00610});
        rows.push_back({i_word(op_addi, 5'd4, 5'd5, 16'h8001), 32'h0000_006c, 18'h00601});
        rows.push_back({i_word(op_andi, 5'd4, 5'd5, 16'hf0f0), 32'h0000_0070, 18'h00E05});
        rows.push_back({i_word(op_ori, 5'd4, 5'd5, 16'h8421), 32'h0000_0074, 18'h01205});
        rows.push_back({i_word(op_xori, 5'd4, 5'd5, 16'hffff), 32'h0000_0078, 18'h01605});
        rows.push_back({i_word(op_lui, 5'd0, 5'd5, 16'h9abc), 32'h0000_007c, 18'h01A05});
        rows.push_back({r_word(5'd3, 5'd4, 5'd5, 5'd12, fn_srl), 32'h0000_0080, 18'h01D81});
        rows.push_back({r_word(5'd7, 5'd8, 5'd9, 5'd0, fn_sllv), 32'h0000_0084, 18'h01C81});
        rows.push_back({r_word(5'd10, 5'd11, 5'd12, 5'd0, fn_srav), 32'h0000_0088, 18'h01C81});
        rows.push_back({r_word(5'd13, 5'd14, 5'd15, 5'd0, fn_subu), 32'h0000_008c, 18'h01C85});
        rows.push_back({r_word(5'd16, 5'd17, 5'd18, 5'd0, fn_and), 32'h0000_0090, 18'h01C85});
        rows.push_back({r_word(5'd19, 5'd20, 5'd21, 5'd0, fn_or), 32'h0000_0094, 18'h01C85});
        rows.push_back({r_word(5'd22, 5'd23, 5'd24, 5'd0, fn_xor), 32'h0000_0098, 18'h01C85});
        rows.push_back({r_word(5'd25, 5'd26, 5'd27, 5'd0, fn_nor), 32'h0000_009c, 18'h01C85});
        rows.push_back({r_word(5'd28, 5'd29, 5'd30, 5'd0, fn_sltu), 32'h0000_00a0, 18'h01C85});
        rows.push_back({i_word(op_lh, 5'd11, 5'd12, 16'h0002), 32'h0000_00a4, 18'h02629});
        rows.push_back({i_word(op_lw, 5'd13, 5'd14, 16'h8000), 32'h0000_00a8, 18'h02609});
        rows.push_back({i_word(op_lwu, 5'd15, 5'd16, 16'h0004), 32'h0000_00ac, 18'h0260D});
        rows.push_back({i_word(op_lbu, 5'd17, 5'd18, 16'h0001), 32'h0000_00b0, 18'h0266D});
        rows.push_back({i_word(op_sb, 5'd19, 5'd20, 16'hffff), 32'h0000_00b4, 18'h00670});
        rows.push_back({i_word(op_sh, 5'd21, 5'd22, 16'h0006), 32'h0000_00b8, 18'h00630});
        rows.push_back({i_word(op_addiu, 5'd23, 5'd24, 16'hfffe), 32'h0000_00bc, 18'h00605});
        rows.push_back({i_word(op_slti, 5'd25, 5'd26, 16'h8000), 32'h0000_00c0, 18'h00A01});
        rows.push_back({i_word(op_sltiu, 5'd27, 5'd28, 16'h7fff), 32'h0000_00c4, 18'h00A05});
        rows.push_back({i_word(op_beq, 5'd8, 5'd9, 16'h0010), 32'h0000_0200, 18'h20002});
        rows.push_back({i_word(op_beq, 5'd8, 5'd10, 16'h0010), 32'h0000_0204, 18'h20002});
        rows.push_back({i_word(op_bne, 5'd8, 5'd10, 16'hfff0), 32'h0000_0208, 18'h28002});
        rows.push_back({i_word(op_bne, 5'd8, 5'd9, 16'hfff0), 32'h0000_020c, 18'h28002});
        rows.push_back({i_word(op_beq, 5'd0, 5'd0, 16'hffff), 32'h0000_0100, 18'h20002});
        rows.push_back({{op_j, 26'h0123456}, 32'ha000_0000, 18'h20000});
        rows.push_back({{op_jal, 26'h3ff_ffff}, 32'h7fff_fffc, 18'h20001}); // Crosses region
        rows.push_back({{6'b111111, 26'h0}, 32'h0000_0300, 18'h00000}); // Undefined opcode
        rows.push_back({r_word(5'd1, 5'd2, 5'd3, 5'd0, 6'b000001), 32'h0000_0304, 18'h00000});
        // Reset, zero reads, writes, readback, table rows, margin
        cycle_limit = reset_cycles + 1 + 32 + 33 + 32 + rows.size() + 50;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < 32; i++) begin // Every register reads zero after reset
            drive_and_check(r_word(5'(i), 5'(31 - i), 5'd0, 5'd0, fn_sll), 32'(4 * i),
                            18'h01D81, 1'b0, 5'd0, '0);
        end
        for (int i = 1; i < 32; i++) begin // Fill registers, each value read through the bypass
            rng = next_random(rng);
            drive_and_check(r_word(5'(i), 5'd0, 5'd0, 5'd0, fn_sll), 32'h0000_1000,
                            18'h01D81, 1'b1, 5'(i), rng);
        end
        drive_and_check(r_word(5'd0, 5'd0, 5'd0, 5'd0, fn_sll), 32'h0, 18'h01D81, 1'b1, 5'd0,
                        32'hdead_beef); // $0 ignores the write
        drive_and_check(r_word(5'd9, 5'd8, 5'd0, 5'd0, fn_sll), 32'h0, 18'h01D81, 1'b1, 5'd9,
                        shadow[8]); // Equal pair for the branches
        for (int i = 0; i < 32; i++) begin // Stored values on both ports
            drive_and_check(r_word(5'(i), 5'(31 - i), 5'd0, 5'd0, fn_sll), 32'(4 * i),
                            18'h01D81, 1'b0, 5'd0, '0);
        end
        foreach (rows[n]) begin
            drive_and_check(rows[n][81:50], rows[n][49:18], rows[n][17:0], 1'b0, 5'd0, '0);
        end
        $display("*** PASSED ***");
        $finish;
    end
endmodule

//--- all.f
isa_pkg.sv
ctrl_pkg.sv
reg_read_if.sv
main_control.sv
register_file.sv
operand_fetch.sv
decode_stage.sv
tb_clock_gen.sv
decode_stage_tb.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := decode_stage_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
